/* hdl/fetch_defines.svh */
/*
 * Global sizing of the fetch front end.
 * Included by the package and by every block that needs line, buffer or credit sizes.
 */

`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Bytes in one memory line, a power of two
`define FETCH_LINE_BYTES 32

// Number of recently filled lines kept by the line buffer
`define FETCH_BUF_DEPTH 4

// Credits the decode stage grants after reset
`define FETCH_CREDITS 4

// Instruction pointer after reset
`define FETCH_RESET_IP 32'h0

`endif

/* hdl/fetch_pkg.sv */
/*
 * Shared types of the fetch front end.
 * Modules name these types by scope in their headers and import them in their bodies.
 */

`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

	// ============================================================
	// Basic words
	// ============================================================

	// Byte address of an instruction or a line
	typedef logic [31:0] addr_t;

	// One fixed-length instruction word
	typedef logic [31:0] insn_t;

	// One full memory line
	// Word k of the line sits in bits 32k+31 down to 32k
	typedef logic [`FETCH_LINE_BYTES*8-1:0] line_t;

	// ============================================================
	// Encodings
	// ============================================================

	// Opcode of the unconditional jump, held in bits 6..0
	// The offset field is bits 31..12, counted in words from the jump itself
	localparam logic [6:0] JUMP_OPCODE = 7'h6f;

	// Instruction as it leaves toward the decode stage
	typedef struct packed {
		insn_t insn;
		addr_t ip;
		logic  is_jump;
	} issue_t;

endpackage

`default_nettype wire

/* hdl/line_lookup_if.sv */
/*
 * Lookup and fill channel of the line buffer.
 * The sequencer drives the pointer and the fill, the buffer answers, the predecoder reads.
 */

`default_nettype none

interface line_lookup_if (
	input var logic clk_i
);
	import fetch_pkg::*;

	// Current instruction pointer
	addr_t ip;

	// Lookup answer, combinational from the buffer
	logic  hit;
	line_t line;

	// Line returned by memory, written into the buffer at the next edge
	logic  fill_valid;
	addr_t fill_addr;
	line_t fill_line;

	modport buffer (input clk_i, input ip, output hit, output line,
		input fill_valid, input fill_addr, input fill_line);

	modport sequencer (input clk_i, output ip, input hit,
		output fill_valid, output fill_addr, output fill_line);

	// The predecoder only looks at the pointer and the returned line
	modport reader (input ip, input line);

endinterface

`default_nettype wire

/* hdl/line_buffer.sv */
/*
 * Small store of the most recently filled lines.
 * Every entry is compared with the pointer in parallel, and a fill drops the oldest entry.
 */

`default_nettype none

`include "fetch_defines.svh"

module line_buffer (
	input  var logic clk_i,
	input  var logic rst_i,
	line_lookup_if.buffer lookup
);
	import fetch_pkg::*;

	localparam int DEPTH = `FETCH_BUF_DEPTH;
	localparam int OFS_W = $clog2(`FETCH_LINE_BYTES);
	localparam int TAG_W = $bits(addr_t) - OFS_W;

	// Slot 0 holds the oldest line, slot DEPTH-1 the newest
	logic [DEPTH-1:0] valid_q;
	logic [TAG_W-1:0] tag_q [DEPTH];
	line_t            data_q [DEPTH];

	logic             hit;
	line_t            line;

	// ============================================================
	// Lookup
	// ============================================================

	// A line is only filled after a miss, so at most one slot can match
	always_comb begin
		hit  = 1'b0;
		line = '0;
		for (int i = 0; i < DEPTH; i++) begin
			if (valid_q[i] && tag_q[i] == lookup.ip[$bits(addr_t)-1:OFS_W]) begin
				hit  = 1'b1;
				line = data_q[i];
			end
		end
	end

	assign lookup.hit  = hit;
	assign lookup.line = line;

	// ============================================================
	// Fill
	// ============================================================

	// Valid bits move along with their entries
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= '0;
		end else if (lookup.fill_valid) begin
			valid_q <= {1'b1, valid_q[DEPTH-1:1]};
		end
	end

	// Tags and lines shift toward slot 0, the new line enters at the top
	always_ff @(posedge clk_i) begin
		if (lookup.fill_valid) begin
			for (int i = 0; i < DEPTH - 1; i++) begin
				tag_q[i]  <= tag_q[i+1];
				data_q[i] <= data_q[i+1];
			end
			tag_q[DEPTH-1]  <= lookup.fill_addr[$bits(addr_t)-1:OFS_W];
			data_q[DEPTH-1] <= lookup.fill_line;
		end
	end

endmodule

`default_nettype wire

/* hdl/predecode.sv */
/*
 * Combinational predecoder.
 * Picks the word at the pointer out of the buffered line and spots unconditional jumps.
 */

`default_nettype none

`include "fetch_defines.svh"

module predecode (
	line_lookup_if.reader lookup,
	output var fetch_pkg::insn_t insn_o,
	output var logic             is_jump_o,
	output var fetch_pkg::addr_t target_o
);
	import fetch_pkg::*;

	localparam int WORDS = `FETCH_LINE_BYTES / 4;
	localparam int OFS_W = $clog2(`FETCH_LINE_BYTES);

	// The line seen as an array of words, word k at bits 32k+31..32k
	insn_t [WORDS-1:0] words;

	// Word index of the pointer inside its line
	logic [OFS_W-3:0] word_idx;

	// Sign-extended byte offset of a jump
	addr_t jump_ofs;

	assign words    = lookup.line;
	assign word_idx = lookup.ip[OFS_W-1:2];

	// ============================================================
	// Word select and jump decode
	// ============================================================

	assign insn_o = words[word_idx];

	// Only the low seven bits tell a jump apart
	assign is_jump_o = (insn_o[6:0] == JUMP_OPCODE);

	// Offset field is in words, so it is shifted left by two
	assign jump_ofs = {{10{insn_o[31]}}, insn_o[31:12], 2'b00};

	// Target is relative to the jump's own address
	// For a non-jump word the value is meaningless and ignored downstream
	assign target_o = lookup.ip + jump_ofs;

endmodule

`default_nettype wire

/* hdl/fetch_sequencer.sv */
/*
 * Owner of the instruction pointer.
 * Issues on a buffer hit when a credit is free, follows jumps, and fetches missing lines.
 */

`default_nettype none

`include "fetch_defines.svh"

module fetch_sequencer (
	input  var logic             clk_i,
	input  var logic             rst_i,
	line_lookup_if.sequencer     lookup,
	input  var logic             is_jump_i,
	input  var fetch_pkg::addr_t target_i,
	input  var logic             can_issue_i,
	output var logic             issue_o,
	output var logic             mem_req_o,
	output var fetch_pkg::addr_t mem_addr_o,
	input  var logic             mem_valid_i,
	input  var fetch_pkg::line_t mem_line_i
);
	import fetch_pkg::*;

	localparam int OFS_W = $clog2(`FETCH_LINE_BYTES);

	// Pointer of the instruction being looked up
	addr_t ip_q;

	// High while a line request is open toward memory, this is the miss state
	logic  req_q;

	// Line address of the open request
	addr_t req_addr_q;

	// Line address of the current pointer
	addr_t ip_line;

	assign ip_line = {ip_q[$bits(addr_t)-1:OFS_W], {OFS_W{1'b0}}};

	// ============================================================
	// Issue decision
	// ============================================================

	// A hit can only go out while decode still has a free credit
	assign issue_o = lookup.hit & can_issue_i;

	// Pointer steps one word, or takes the target when the jump goes out
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ip_q <= `FETCH_RESET_IP;
		end else if (issue_o) begin
			if (is_jump_i) begin
				ip_q <= target_i;
			end else begin
				ip_q <= ip_q + 32'd4;
			end
		end
	end

	assign lookup.ip = ip_q;

	// ============================================================
	// Miss handling
	// ============================================================

	// A miss opens the request one edge later
	// The request closes at the edge that samples the answer
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_q <= 1'b0;
		end else if (!req_q && !lookup.hit) begin
			req_q <= 1'b1;
		end else if (req_q && mem_valid_i) begin
			req_q <= 1'b0;
		end
	end

	// Address is captured together with the opening of the request
	always_ff @(posedge clk_i) begin
		if (!req_q && !lookup.hit) begin
			req_addr_q <= ip_line;
		end
	end

	assign mem_req_o  = req_q;
	assign mem_addr_o = req_addr_q;

	// Returned line goes straight into the buffer, next cycle then hits
	assign lookup.fill_valid = req_q & mem_valid_i;
	assign lookup.fill_addr  = req_addr_q;
	assign lookup.fill_line  = mem_line_i;

endmodule

`default_nettype wire

/* hdl/issue_stage.sv */
/*
 * Output register toward the decode stage with credit flow control.
 * One credit is spent per issued instruction and returned by each credit pulse.
 */

`default_nettype none

`include "fetch_defines.svh"

module issue_stage (
	input  var logic             clk_i,
	input  var logic             rst_i,
	input  var logic             issue_i,
	input  var fetch_pkg::insn_t insn_i,
	input  var fetch_pkg::addr_t ip_i,
	input  var logic             is_jump_i,
	input  var logic             credit_i,
	output var logic             can_issue_o,
	output var logic             insn_valid_o,
	output var fetch_pkg::insn_t insn_o,
	output var fetch_pkg::addr_t insn_ip_o,
	output var logic             insn_is_jump_o
);
	import fetch_pkg::*;

	localparam int CNT_W = $clog2(`FETCH_CREDITS + 1);

	// Credits still available to spend
	logic [CNT_W-1:0] credits_q;

	// Registered instruction
	logic   valid_q;
	issue_t out_q;

	// ============================================================
	// Credit counter
	// ============================================================

	// An issue and a returned credit in one cycle cancel out
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			credits_q <= CNT_W'(`FETCH_CREDITS);
		end else if (issue_i && !credit_i) begin
			credits_q <= credits_q - 1'b1;
		end else if (credit_i && !issue_i) begin
			credits_q <= credits_q + 1'b1;
		end
	end

	// Nothing goes out while decode has no room
	assign can_issue_o = (credits_q != '0);

	// ============================================================
	// Output register
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= issue_i;
		end
	end

	// Payload follows the issue strobe
	always_ff @(posedge clk_i) begin
		if (issue_i) begin
			out_q <= '{insn: insn_i, ip: ip_i, is_jump: is_jump_i};
		end
	end

	assign insn_valid_o   = valid_q;
	assign insn_o         = out_q.insn;
	assign insn_ip_o      = out_q.ip;
	assign insn_is_jump_o = out_q.is_jump;

endmodule

`default_nettype wire

/* hdl/fetch_top.sv */
/*
 * Top level of the fetch front end.
 * Memory, issue and credit signals are plain ports, the line channel stays inside.
 */

`default_nettype none

module fetch_top (
	input  var logic             clk_i,
	input  var logic             rst_i,
	// Memory line port
	output var logic             mem_req_o,
	output var fetch_pkg::addr_t mem_addr_o,
	input  var logic             mem_valid_i,
	input  var fetch_pkg::line_t mem_line_i,
	// Issue port toward decode
	output var logic             insn_valid_o,
	output var fetch_pkg::insn_t insn_o,
	output var fetch_pkg::addr_t insn_ip_o,
	output var logic             insn_is_jump_o,
	input  var logic             credit_i
);
	import fetch_pkg::*;

	// Predecoder results
	insn_t pd_insn;
	logic  pd_is_jump;
	addr_t pd_target;

	// Handshake between sequencer and issue stage
	logic  can_issue;
	logic  issue;

	// Lookup and fill channel shared by three blocks
	line_lookup_if lookup (.clk_i(clk_i));

	line_buffer u_line_buffer (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.lookup (lookup.buffer)
	);

	predecode u_predecode (
		.lookup    (lookup.reader),
		.insn_o    (pd_insn),
		.is_jump_o (pd_is_jump),
		.target_o  (pd_target)
	);

	fetch_sequencer u_sequencer (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.lookup      (lookup.sequencer),
		.is_jump_i   (pd_is_jump),
		.target_i    (pd_target),
		.can_issue_i (can_issue),
		.issue_o     (issue),
		.mem_req_o   (mem_req_o),
		.mem_addr_o  (mem_addr_o),
		.mem_valid_i (mem_valid_i),
		.mem_line_i  (mem_line_i)
	);

	// The issued address is the pointer that was looked up
	issue_stage u_issue (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.issue_i        (issue),
		.insn_i         (pd_insn),
		.ip_i           (lookup.ip),
		.is_jump_i      (pd_is_jump),
		.credit_i       (credit_i),
		.can_issue_o    (can_issue),
		.insn_valid_o   (insn_valid_o),
		.insn_o         (insn_o),
		.insn_ip_o      (insn_ip_o),
		.insn_is_jump_o (insn_is_jump_o)
	);

endmodule

`default_nettype wire

/* verification/tb_fetch.sv */
/*
 * Testbench of the fetch front end with a latency-varying memory model and credit return.
 * Issued instructions are checked against a reference pointer sequence and line buffer model.
 */

`default_nettype none

`include "fetch_defines.svh"

module tb_fetch;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_INSNS = 150;
	localparam int TIMEOUT = 200;

	logic             clk_i;
	logic             rst_i;
	logic             mem_req_o;
	fetch_pkg::addr_t mem_addr_o;
	logic             mem_valid_i;
	fetch_pkg::line_t mem_line_i;
	logic             insn_valid_o;
	fetch_pkg::insn_t insn_o;
	fetch_pkg::addr_t insn_ip_o;
	logic             insn_is_jump_o;
	logic             credit_i;

	logic [31:0]      lfsr_q = 32'hfe922b13;
	logic [31:0]      buf_q[$];

	fetch_top u_dut (.*);

	// ============================================================
	// Helpers
	// ============================================================

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	// Planted jumps of the program and where each one goes
	function automatic logic is_planted(input logic [31:0] a);
		return a == 32'h38 || a == 32'h13c || a == 32'hfc;
	endfunction

	function automatic logic [31:0] planted_target(input logic [31:0] a);
		case (a)
			32'h38:  return 32'h100;
			32'h13c: return 32'hc0;
			default: return 32'h0;
		endcase
	endfunction

	// Word offset lives in bits 31..12, counted from the jump itself
	function automatic logic [31:0] mem_word(input logic [31:0] a);
		logic [31:0] d;
		d = planted_target(a) - a;
		if (is_planted(a))
			return {d[21:2], 5'b0, 7'h6f};
		// Plain words carry opcode 7'h13 and the address bits above it
		return {a[24:0], 7'h13};
	endfunction

	function automatic fetch_pkg::line_t make_line(input logic [31:0] la);
		fetch_pkg::line_t l;
		for (int k = 0; k < 8; k++)
			l[32*k +: 32] = mem_word(la + 32'(4 * k));
		return l;
	endfunction

	function automatic logic in_buffer(input logic [31:0] la);
		foreach (buf_q[i])
			if (buf_q[i] == la)
				return 1'b1;
		return 1'b0;
	endfunction

	// ============================================================
	// Clock and memory model
	// ============================================================

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// Each open request gets one answer after a random latency of 1 to 8 cycles
	initial begin
		logic [31:0] addr;
		int          lat;
		mem_valid_i = 1'b0;
		mem_line_i  = '0;
		forever begin
			@(posedge clk_i);
			#1;
			if (!rst_i && mem_req_o) begin
				addr = mem_addr_o;
				assert (addr[4:0] == 5'h0)
				else report_error($sformatf("FAIL mem_addr_o unaligned got %h", addr));
				assert (!in_buffer(addr))
				else report_error($sformatf("FAIL mem_addr_o %h requested while buffered", addr));
				lat = 1 + int'(rand_bits(3));
				repeat (lat - 1) begin
					@(posedge clk_i);
					#1;
				end
				mem_valid_i = 1'b1;
				mem_line_i  = make_line(addr);
				// The model drops its oldest line just like the DUT
				buf_q.push_back(addr);
				if (buf_q.size() > `FETCH_BUF_DEPTH)
					void'(buf_q.pop_front());
				@(posedge clk_i);
				#1;
				mem_valid_i = 1'b0;
			end
		end
	end

	// ============================================================
	// Stimulus and checks
	// ============================================================

	initial begin
		logic [31:0] exp_ip;
		int          n_issued;
		int          idle;
		int          outstanding;
		int          credit_timer;
		int          hold_cycles;
		logic        full_seen;
		rst_i        = 1'b1;
		credit_i     = 1'b0;
		exp_ip       = `FETCH_RESET_IP;
		n_issued     = 0;
		idle         = 0;
		outstanding  = 0;
		credit_timer = 0;
		hold_cycles  = 0;
		full_seen    = 1'b0;
		repeat (3) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		assert (!insn_valid_o && !mem_req_o)
		else report_error("Outputs were active right after reset");

		while (n_issued < N_INSNS) begin
			@(posedge clk_i);
			#1;
			credit_i = 1'b0;
			idle++;
			assert (idle < TIMEOUT)
			else report_error("No instruction was issued within the timeout");
			if (insn_valid_o) begin
				idle = 0;
				assert (insn_ip_o == exp_ip)
				else report_error($sformatf("FAIL insn_ip_o got %h expected %h", insn_ip_o, exp_ip));
				assert (insn_o == mem_word(exp_ip))
				else report_error($sformatf("FAIL insn_o got %h expected %h",
					insn_o, mem_word(exp_ip)));
				assert (insn_is_jump_o == is_planted(exp_ip))
				else report_error($sformatf("FAIL insn_is_jump_o got %h expected %h",
					insn_is_jump_o, is_planted(exp_ip)));
				// A line dropped by the model has to be fetched again before it issues
				assert (in_buffer({exp_ip[31:5], 5'h0}))
				else report_error($sformatf("FAIL insn_ip_o %h issued from a line not in the model",
					insn_ip_o));
				exp_ip = is_planted(exp_ip) ? planted_target(exp_ip) : exp_ip + 32'd4;
				n_issued++;
				outstanding++;
				assert (outstanding <= `FETCH_CREDITS)
				else report_error($sformatf("FAIL outstanding got %h limit %h",
					outstanding, `FETCH_CREDITS));
			end
			// Credits are withheld for a while so that the counter runs dry
			if (n_issued >= 40 && hold_cycles < 30) begin
				hold_cycles++;
				if (outstanding == `FETCH_CREDITS)
					full_seen = 1'b1;
			end else if (outstanding > 0) begin
				if (credit_timer == 0) begin
					credit_i     = 1'b1;
					outstanding--;
					credit_timer = int'(rand_bits(2));
				end else begin
					credit_timer--;
				end
			end
		end

		assert (full_seen)
		else report_error("Credits never ran out while they were withheld");

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/fetch_pkg.sv
hdl/line_lookup_if.sv
hdl/line_buffer.sv
hdl/predecode.sv
hdl/fetch_sequencer.sv
hdl/issue_stage.sv
hdl/fetch_top.sv
verification/tb_fetch.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the fetch front end testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 --top-module tb_fetch -f list.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/Vtb_fetch > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if ! grep -q "ALL TESTS PASSED" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi

exit 0
